//--- hdl/tx_gen_pkg.sv
package tx_gen_pkg;

    // generator modes
    // codes 5 to 7 are not defined and act like MODE_RESET
    typedef enum logic [2:0] {
        MODE_RESET    = 3'd0,
        MODE_CONSTANT = 3'd1,
        MODE_PULSE    = 3'd2,
        MODE_SQUARE   = 3'd3,
        MODE_PRBS     = 3'd4
    } data_mode_e;

    // pulse and square period
    localparam int PER_W = 16;

    // checker error counter, saturating
    localparam int CNT_W = 16;

    // debug inversion field
    localparam int CHK_W = 2;

    // invert the line bit after error injection
    localparam int CHK_INV_OUT = 0;

    // invert the lfsr feedback
    localparam int CHK_INV_FB = 1;

endpackage

//--- hdl/gen_ctrl_if.sv
`timescale 1ns/100ps

interface gen_ctrl_if #(
    parameter int nprbs = 32,
    parameter int nti = 16
);

    // captured settings, all change on the same edge
    logic                              soft_rst;
    logic                              cke;
    tx_gen_pkg::data_mode_e            mode;
    logic [tx_gen_pkg::PER_W-1:0]      per;
    logic [nti-1:0]                    data_in;

    // one start value per lane
    logic [nti-1:0][nprbs-1:0]         prbs_init;
    logic [nprbs-1:0]                  prbs_eqn;
    logic [nti-1:0]                    prbs_inj_err;
    logic [tx_gen_pkg::CHK_W-1:0]      prbs_chicken;

    modport cap (
        output soft_rst,
        output cke,
        output mode,
        output per,
        output data_in,
        output prbs_init,
        output prbs_eqn,
        output prbs_inj_err,
        output prbs_chicken
    );

    modport gen (
        input soft_rst,
        input cke,
        input mode,
        input per,
        input data_in,
        input prbs_init,
        input prbs_eqn,
        input prbs_inj_err,
        input prbs_chicken
    );

    // checker only needs what shapes the received sequence
    modport chk (
        input soft_rst,
        input cke,
        input mode,
        input prbs_eqn,
        input prbs_chicken
    );

endinterface

//--- hdl/exec_ctrl_capture.sv
`timescale 1ns/100ps

module exec_ctrl_capture #(
    parameter int nprbs = 32,
    parameter int nti = 16
) (
    input  logic                         clk,
    input  logic                         rst_d,
    input  logic                         exec,
    input  logic                         soft_rst,
    input  logic                         cke,
    input  tx_gen_pkg::data_mode_e       data_mode,
    input  logic [tx_gen_pkg::PER_W-1:0] data_per,
    input  logic [nti-1:0]               data_in,
    input  logic [nti-1:0][nprbs-1:0]    prbs_init,
    input  logic [nprbs-1:0]             prbs_eqn,
    input  logic [nti-1:0]               prbs_inj_err,
    input  logic [tx_gen_pkg::CHK_W-1:0] prbs_chicken,
    gen_ctrl_if.cap                      ctrl
);

    logic exec_m;
    logic exec_s;

    // two-flop synchronizer for the host strobe
    always_ff @(posedge clk) begin
        if (rst_d) begin
            exec_m <= 1'b0;
            exec_s <= 1'b0;
        end else begin
            exec_m <= exec;
            exec_s <= exec_m;
        end
    end

    // control fields come out of reset with the generator parked
    always_ff @(posedge clk) begin
        if (rst_d) begin
            ctrl.soft_rst <= 1'b1;
            ctrl.cke      <= 1'b0;
            ctrl.mode     <= tx_gen_pkg::MODE_RESET;
        end else if (exec_s) begin
            ctrl.soft_rst <= soft_rst;
            ctrl.cke      <= cke;
            ctrl.mode     <= data_mode;
        end
    end

    // pattern settings load on the same edge as the controls
    // host inputs are static while exec is high, so no per-bit sync
    always_ff @(posedge clk) begin
        if (exec_s) begin
            ctrl.per          <= data_per;
            ctrl.data_in      <= data_in;
            ctrl.prbs_init    <= prbs_init;
            ctrl.prbs_eqn     <= prbs_eqn;
            ctrl.prbs_inj_err <= prbs_inj_err;
            ctrl.prbs_chicken <= prbs_chicken;
        end
    end

endmodule

//--- hdl/prbs_lane.sv
`timescale 1ns/100ps

module prbs_lane #(
    parameter int nprbs = 32
) (
    input  logic                         clk,
    input  logic                         soft_rst,
    input  logic                         cke,
    input  logic [nprbs-1:0]             init_val,
    input  logic [nprbs-1:0]             eqn,
    input  logic                         inj_err,
    input  logic [tx_gen_pkg::CHK_W-1:0] chicken,
    output logic                         line_bit
);

    logic [nprbs-1:0] state;
    logic             fb;

    // fibonacci feedback over the selected taps
    assign fb = (^(state & eqn)) ^ chicken[tx_gen_pkg::CHK_INV_FB];

    // injected errors reach the line only, the lfsr stays clean
    // so a checker can resync after the error burst
    assign line_bit = fb ^ inj_err ^ chicken[tx_gen_pkg::CHK_INV_OUT];

    // soft reset reloads the seed, cke low freezes the sequence
    always_ff @(posedge clk) begin
        if (soft_rst) begin
            state <= init_val;
        end else if (cke) begin
            state <= {state[nprbs-2:0], fb};
        end
    end

endmodule

//--- hdl/pattern_gen.sv
`timescale 1ns/100ps

module pattern_gen #(
    parameter int nprbs = 32,
    parameter int nti = 16
) (
    input  logic           clk,
    input  logic           rst_d,
    gen_ctrl_if.gen        ctrl,
    output logic [nti-1:0] data_out
);

    logic [nti-1:0]                 lane_bits;
    logic [tx_gen_pkg::PER_W-1:0]   per_cnt;
    logic [nti-1:0]                 data_q;

    // one lfsr per lane, all sharing the tap mask
    for (genvar i = 0; i < nti; i++) begin : g_lane
        prbs_lane #(
            .nprbs(nprbs)
        ) i_prbs_lane (
            .clk(clk),
            .soft_rst(ctrl.soft_rst),
            .cke(ctrl.cke),
            .init_val(ctrl.prbs_init[i]),
            .eqn(ctrl.prbs_eqn),
            .inj_err(ctrl.prbs_inj_err[i]),
            .chicken(ctrl.prbs_chicken),
            .line_bit(lane_bits[i])
        );
    end

    // output register and period counter
    always_ff @(posedge clk) begin
        if (rst_d || ctrl.soft_rst) begin
            per_cnt <= '0;
            data_q  <= '0;
        end else begin
            case (ctrl.mode)
                tx_gen_pkg::MODE_CONSTANT: begin
                    per_cnt <= '0;
                    data_q  <= ctrl.data_in;
                end
                tx_gen_pkg::MODE_PULSE: begin
                    // one word of data_in every per+1 cycles
                    if (per_cnt == ctrl.per) begin
                        per_cnt <= '0;
                        data_q  <= ctrl.data_in;
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                        data_q  <= '0;
                    end
                end
                tx_gen_pkg::MODE_SQUARE: begin
                    // starts from the zero word left by reset mode
                    if (per_cnt == ctrl.per) begin
                        per_cnt <= '0;
                        data_q  <= ~data_q;
                    end else begin
                        per_cnt <= per_cnt + 1'b1;
                    end
                end
                tx_gen_pkg::MODE_PRBS: begin
                    per_cnt <= '0;
                    data_q  <= lane_bits;
                end
                default: begin
                    per_cnt <= '0;
                    data_q  <= '0;
                end
            endcase
        end
    end

    assign data_out = data_q;

endmodule

//--- hdl/prbs_rx_checker.sv
`timescale 1ns/100ps

module prbs_rx_checker #(
    parameter int nprbs = 32,
    parameter int nti = 16
) (
    input  logic                         clk,
    input  logic                         rst_d,
    gen_ctrl_if.chk                      ctrl,
    input  logic [nti-1:0]               rx_word,
    output logic [tx_gen_pkg::CNT_W-1:0] err_count,
    output logic [nti-1:0]               err_lanes
);

    localparam int FILL_W = $clog2(nprbs + 1);
    localparam int SUM_W = $clog2(nti + 1);
    localparam int ACC_W = tx_gen_pkg::CNT_W + 1;

    logic             word_ok;
    logic             adv_q;
    logic             adv_ok;
    logic             inv_out_q;
    logic [nti-1:0]   mismatch;
    logic [SUM_W-1:0] n_err;
    logic [ACC_W-1:0] acc;

    // align the settings with the word on rx_word
    // word_ok: word came from prbs mode out of soft reset
    // adv_ok: lane state moved two cycles back, so this word is a new bit
    always_ff @(posedge clk) begin
        if (rst_d) begin
            word_ok <= 1'b0;
            adv_q   <= 1'b0;
            adv_ok  <= 1'b0;
        end else begin
            word_ok <= (ctrl.mode == tx_gen_pkg::MODE_PRBS) && !ctrl.soft_rst;
            adv_q   <= ctrl.cke || ctrl.soft_rst;
            adv_ok  <= adv_q;
        end
    end

    always_ff @(posedge clk) begin
        inv_out_q <= ctrl.prbs_chicken[tx_gen_pkg::CHK_INV_OUT];
    end

    for (genvar i = 0; i < nti; i++) begin : g_lane
        logic [nprbs-1:0]  hist;
        logic [FILL_W-1:0] fill;
        logic              rx_bit;
        logic              exp_bit;

        assign rx_bit  = rx_word[i] ^ inv_out_q;
        assign exp_bit = (^(hist & ctrl.prbs_eqn)) ^ ctrl.prbs_chicken[tx_gen_pkg::CHK_INV_FB];

        // only judge once the history holds a full lfsr state
        assign mismatch[i] = word_ok && adv_ok && (fill == FILL_W'(nprbs)) &&
                             (rx_bit != exp_bit);

        always_ff @(posedge clk) begin
            if (word_ok && adv_ok) begin
                hist <= {hist[nprbs-2:0], rx_bit};
            end
        end

        always_ff @(posedge clk) begin
            if (rst_d || !word_ok) begin
                fill <= '0;
            end else if (adv_ok && (fill != FILL_W'(nprbs))) begin
                fill <= fill + 1'b1;
            end
        end
    end

    // lanes in error this cycle
    always_comb begin
        n_err = '0;
        for (int i = 0; i < nti; i++) begin
            n_err = n_err + SUM_W'(mismatch[i]);
        end
        acc = {1'b0, err_count} + ACC_W'(n_err);
    end

    always_ff @(posedge clk) begin
        if (rst_d || !word_ok) begin
            err_count <= '0;
            err_lanes <= '0;
        end else begin
            // saturate instead of wrapping
            err_count <= acc[ACC_W-1] ? '1 : acc[ACC_W-2:0];
            err_lanes <= err_lanes | mismatch;
        end
    end

endmodule

//--- hdl/tx_bist_top.sv
`timescale 1ns/100ps

module tx_bist_top #(
    parameter int nprbs = 32,
    parameter int nti = 16
) (
    input  logic                         clk,
    input  logic                         rst_d,
    input  logic                         exec,
    input  logic                         soft_rst,
    input  logic                         cke,
    input  tx_gen_pkg::data_mode_e       data_mode,
    input  logic [tx_gen_pkg::PER_W-1:0] data_per,
    input  logic [nti-1:0]               data_in,
    input  logic [nti-1:0][nprbs-1:0]    prbs_init,
    input  logic [nprbs-1:0]             prbs_eqn,
    input  logic [nti-1:0]               prbs_inj_err,
    input  logic [tx_gen_pkg::CHK_W-1:0] prbs_chicken,
    output logic [nti-1:0]               data_out,
    output logic [tx_gen_pkg::CNT_W-1:0] err_count,
    output logic [nti-1:0]               err_lanes
);

    gen_ctrl_if #(
        .nprbs(nprbs),
        .nti(nti)
    ) ctrl ();

    exec_ctrl_capture #(
        .nprbs(nprbs),
        .nti(nti)
    ) i_capture (
        .clk(clk),
        .rst_d(rst_d),
        .exec(exec),
        .soft_rst(soft_rst),
        .cke(cke),
        .data_mode(data_mode),
        .data_per(data_per),
        .data_in(data_in),
        .prbs_init(prbs_init),
        .prbs_eqn(prbs_eqn),
        .prbs_inj_err(prbs_inj_err),
        .prbs_chicken(prbs_chicken),
        .ctrl(ctrl.cap)
    );

    pattern_gen #(
        .nprbs(nprbs),
        .nti(nti)
    ) i_gen (
        .clk(clk),
        .rst_d(rst_d),
        .ctrl(ctrl.gen),
        .data_out(data_out)
    );

    // loopback of the transmitted word
    prbs_rx_checker #(
        .nprbs(nprbs),
        .nti(nti)
    ) i_checker (
        .clk(clk),
        .rst_d(rst_d),
        .ctrl(ctrl.chk),
        .rx_word(data_out),
        .err_count(err_count),
        .err_lanes(err_lanes)
    );

endmodule

//--- dv/tx_bist_monitor.sv
`timescale 1ns/100ps

module tx_bist_monitor #(
    parameter int nprbs = 32,
    parameter int nti = 16
) (
    input  logic                         clk,
    input  logic                         rst_d,
    input  logic                         exec,
    input  logic                         soft_rst,
    input  logic                         cke,
    input  tx_gen_pkg::data_mode_e       data_mode,
    input  logic [tx_gen_pkg::PER_W-1:0] data_per,
    input  logic [nti-1:0]               data_in,
    input  logic [nti-1:0][nprbs-1:0]    prbs_init,
    input  logic [nprbs-1:0]             prbs_eqn,
    input  logic [nti-1:0]               prbs_inj_err,
    input  logic [tx_gen_pkg::CHK_W-1:0] prbs_chicken,
    input  logic [nti-1:0]               data_out,
    input  logic [tx_gen_pkg::CNT_W-1:0] err_count,
    input  logic [nti-1:0]               err_lanes,
    output int                           n_err
);

    localparam int CNT_MAX = (1 << tx_gen_pkg::CNT_W) - 1;

    // exec synchronizer and captured settings
    logic                         e_m;
    logic                         e_s;
    logic                         c_soft;
    logic                         c_cke;
    tx_gen_pkg::data_mode_e       c_mode;
    logic [tx_gen_pkg::PER_W-1:0] c_per;
    logic [nti-1:0]               c_din;
    logic [nti-1:0][nprbs-1:0]    c_init;
    logic [nprbs-1:0]             c_eqn;
    logic [nti-1:0]               c_inj;
    logic [tx_gen_pkg::CHK_W-1:0] c_chk;
    // generator, with tags that travel with the word on data_out
    logic [nprbs-1:0]             st [nti];
    logic [nti-1:0]               fb;
    logic [tx_gen_pkg::PER_W-1:0] cnt;
    logic [nti-1:0]               dout;
    logic                         moved;
    logic                         w_ok;
    logic                         w_new;
    logic                         w_inv;
    // loopback checker
    logic [nprbs-1:0]             hist [nti];
    int                           fill [nti];
    int                           ecnt;
    logic [nti-1:0]               elanes;
    logic                         armed = 1'b0;
    int                           errs = 0;

    assign n_err = errs;

    // model state after each edge, updated from the last stage back
    always @(posedge clk) begin
        int   nerr;
        logic rx;
        logic expb;
        nerr = 0;
        if (rst_d) begin
            e_m = 1'b0;
            e_s = 1'b0;
            c_soft = 1'b1;
            c_cke = 1'b0;
            c_mode = tx_gen_pkg::MODE_RESET;
            cnt = '0;
            dout = '0;
            moved = 1'b0;
            w_ok = 1'b0;
            w_new = 1'b0;
            w_inv = 1'b0;
            ecnt = 0;
            elanes = '0;
            armed = 1'b0;
            for (int i = 0; i < nti; i++) begin
                fill[i] = 0;
            end
        end else begin
            armed = 1'b1;
            // judge the word now on data_out
            if (!w_ok) begin
                ecnt = 0;
                elanes = '0;
                for (int i = 0; i < nti; i++) begin
                    fill[i] = 0;
                end
            end else if (w_new) begin
                for (int i = 0; i < nti; i++) begin
                    rx = dout[i] ^ w_inv;
                    expb = (^(hist[i] & c_eqn)) ^ c_chk[tx_gen_pkg::CHK_INV_FB];
                    if (fill[i] == nprbs && rx != expb) begin
                        nerr++;
                        elanes[i] = 1'b1;
                    end
                    hist[i] = {hist[i][nprbs-2:0], rx};
                    if (fill[i] < nprbs) begin
                        fill[i]++;
                    end
                end
                ecnt = (ecnt + nerr > CNT_MAX) ? CNT_MAX : ecnt + nerr;
            end
            for (int i = 0; i < nti; i++) begin
                fb[i] = (^(st[i] & c_eqn)) ^ c_chk[tx_gen_pkg::CHK_INV_FB];
            end
            w_ok = (c_mode == tx_gen_pkg::MODE_PRBS) && !c_soft;
            w_new = moved;
            w_inv = c_chk[tx_gen_pkg::CHK_INV_OUT];
            if (c_soft) begin
                cnt = '0;
                dout = '0;
            end else begin
                case (c_mode)
                    tx_gen_pkg::MODE_CONSTANT: begin
                        cnt = '0;
                        dout = c_din;
                    end
                    tx_gen_pkg::MODE_PULSE: begin
                        dout = (cnt == c_per) ? c_din : '0;
                        cnt = (cnt == c_per) ? '0 : cnt + 1'b1;
                    end
                    tx_gen_pkg::MODE_SQUARE: begin
                        dout = (cnt == c_per) ? ~dout : dout;
                        cnt = (cnt == c_per) ? '0 : cnt + 1'b1;
                    end
                    tx_gen_pkg::MODE_PRBS: begin
                        cnt = '0;
                        dout = fb ^ c_inj ^ {nti{c_chk[tx_gen_pkg::CHK_INV_OUT]}};
                    end
                    default: begin
                        cnt = '0;
                        dout = '0;
                    end
                endcase
            end
            // lane lfsrs step with the settings held before this edge
            moved = c_soft || c_cke;
            for (int i = 0; i < nti; i++) begin
                if (c_soft) begin
                    st[i] = c_init[i];
                end else if (c_cke) begin
                    st[i] = {st[i][nprbs-2:0], fb[i]};
                end
            end
            if (e_s) begin
                c_soft = soft_rst;
                c_cke = cke;
                c_mode = data_mode;
                c_per = data_per;
                c_din = data_in;
                c_init = prbs_init;
                c_eqn = prbs_eqn;
                c_inj = prbs_inj_err;
                c_chk = prbs_chicken;
            end
            e_s = e_m;
            e_m = exec;
        end
    end

    always @(negedge clk) begin
        if (armed) begin
            if (data_out !== dout) begin
                $display("ERR %0t: data_out is %h, model expects %h", $time, data_out, dout);
                errs++;
            end
            if (err_count !== ecnt[tx_gen_pkg::CNT_W-1:0]) begin
                $display("ERR %0t: err_count is %0d, model expects %0d", $time, err_count, ecnt);
                errs++;
            end
            if (err_lanes !== elanes) begin
                $display("ERR %0t: err_lanes is %h, model expects %h", $time, err_lanes, elanes);
                errs++;
            end
        end
    end

endmodule

//--- dv/tb_tx_bist.sv
`timescale 1ns/100ps

module tb_tx_bist;

    localparam int nprbs = 32;
    localparam int nti = 16;
    localparam int PER_W = tx_gen_pkg::PER_W;
    localparam int CHK_W = tx_gen_pkg::CHK_W;
    localparam int WAIT_LIMIT = 20;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [nprbs-1:0] MAX_TAPS = 32'h8020_0003;

    logic                         clk;
    logic                         rst_d;
    logic                         exec;
    logic                         soft_rst;
    logic                         cke;
    tx_gen_pkg::data_mode_e       data_mode;
    logic [PER_W-1:0]             data_per;
    logic [nti-1:0]               data_in;
    logic [nti-1:0][nprbs-1:0]    prbs_init;
    logic [nprbs-1:0]             prbs_eqn;
    logic [nti-1:0]               prbs_inj_err;
    logic [CHK_W-1:0]             prbs_chicken;
    logic [nti-1:0]               data_out;
    logic [tx_gen_pkg::CNT_W-1:0] err_count;
    logic [nti-1:0]               err_lanes;

    int          mon_errs;
    int          local_errs;
    int          test_start;
    int          tests_run;
    int          tests_failed;
    logic [31:0] lcg_state;

    tx_bist_top #(
        .nprbs(nprbs),
        .nti(nti)
    ) i_dut (.*);

    tx_bist_monitor #(
        .nprbs(nprbs),
        .nti(nti)
    ) i_mon (
        .n_err(mon_errs),
        .*
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    // exec high for one edge, then wait until the capture has happened
    task automatic apply_settings();
        exec = 1'b1;
        @(negedge clk);
        exec = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic run_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wait_for_word(input logic [nti-1:0] want);
        int n;
        n = 0;
        while (data_out !== want && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (data_out !== want) begin
            $display("timeout: data_out did not show %h within %0d cycles", want, WAIT_LIMIT);
            local_errs++;
        end
    endtask

    task automatic wait_for_clear();
        int n;
        n = 0;
        while ((err_count !== '0 || err_lanes !== '0) && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (err_count !== '0 || err_lanes !== '0) begin
            $display("timeout: checker counts were not cleared within %0d cycles", WAIT_LIMIT);
            local_errs++;
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, want);
            local_errs++;
        end
    endtask

    // soft reset with fresh seeds, then release into a running PRBS
    task automatic start_prbs(input logic [CHK_W-1:0] chk);
        soft_rst = 1'b1;
        cke = 1'b1;
        data_mode = tx_gen_pkg::MODE_PRBS;
        prbs_eqn = MAX_TAPS;
        prbs_chicken = chk;
        prbs_inj_err = '0;
        for (int i = 0; i < nti; i++) begin
            prbs_init[i] = nprbs'(next_rand()) | nprbs'(1);
        end
        apply_settings();
        soft_rst = 1'b0;
        apply_settings();
    endtask

    task automatic start_test();
        local_errs = 0;
    endtask

    // monitor counts settle on the falling edge, read them on the rising one
    task automatic end_test(input string name);
        int errs;
        @(posedge clk);
        errs = mon_errs - test_start + local_errs;
        test_start = mon_errs;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
            tests_failed++;
        end
        @(negedge clk);
    endtask

    initial begin
        logic [31:0]    r;
        logic [nti-1:0] inj_mask;
        clk = 1'b0;
        lcg_state = 32'd36942;
        tests_run = 0;
        tests_failed = 0;
        local_errs = 0;
        test_start = 0;
        rst_d = 1'b1;
        exec = 1'b0;
        soft_rst = 1'b1;
        cke = 1'b0;
        data_mode = tx_gen_pkg::MODE_RESET;
        data_per = '0;
        data_in = '0;
        prbs_init = '0;
        prbs_eqn = MAX_TAPS;
        prbs_inj_err = '0;
        prbs_chicken = '0;
        repeat (4) @(negedge clk);
        rst_d = 1'b0;
        @(negedge clk);

        start_test();
        check_value("data_out after reset", 32'(data_out), 32'd0);
        check_value("err_count after reset", 32'(err_count), 32'd0);
        check_value("err_lanes after reset", 32'(err_lanes), 32'd0);
        soft_rst = 1'b0;
        cke = 1'b1;
        data_mode = tx_gen_pkg::MODE_CONSTANT;
        for (int i = 0; i < 4; i++) begin
            data_in = nti'(next_rand() >> 8);
            apply_settings();
            wait_for_word(data_in);
            run_cycles(2);
        end
        end_test("reset and constant");

        start_test();
        for (int i = 0; i < 4; i++) begin
            // park in reset mode so the period counter restarts from zero
            data_mode = tx_gen_pkg::MODE_RESET;
            apply_settings();
            data_mode = tx_gen_pkg::MODE_PULSE;
            data_per = PER_W'((next_rand() >> 8) % 21);
            data_in = nti'(next_rand()) | nti'(1);
            apply_settings();
            run_cycles(4 * (int'(data_per) + 1));
        end
        end_test("pulse");

        start_test();
        for (int i = 0; i < 3; i++) begin
            data_mode = tx_gen_pkg::MODE_RESET;
            apply_settings();
            data_mode = tx_gen_pkg::MODE_SQUARE;
            data_per = PER_W'((next_rand() >> 8) % 21);
            apply_settings();
            run_cycles(4 * (int'(data_per) + 1));
        end
        end_test("square");

        // plain, output inverted, feedback inverted, then cke toggling
        start_test();
        for (int v = 0; v < 3; v++) begin
            start_prbs(CHK_W'(v));
            run_cycles(80);
            check_value("err_count in prbs", 32'(err_count), 32'd0);
        end
        start_prbs('0);
        for (int i = 0; i < 10; i++) begin
            r = next_rand();
            cke = r[12];
            apply_settings();
            run_cycles(int'(r[7:5]));
        end
        check_value("err_count with cke toggling", 32'(err_count), 32'd0);
        end_test("prbs");

        start_test();
        start_prbs('0);
        run_cycles(50);
        r = next_rand();
        inj_mask = nti'(r) | nti'(1);
        prbs_inj_err = inj_mask;
        apply_settings();
        prbs_inj_err = '0;
        apply_settings();
        run_cycles(40);
        if (err_count == '0) begin
            $display("ERR %0t: err_count stayed at zero after error injection", $time);
            local_errs++;
        end
        check_value("injected lanes in err_lanes", 32'(err_lanes & inj_mask), 32'(inj_mask));
        data_mode = tx_gen_pkg::MODE_RESET;
        apply_settings();
        wait_for_word('0);
        wait_for_clear();
        end_test("error injection");

        @(posedge clk);
        $display("%0d tests run, %0d failed, %0d monitor mismatches",
                 tests_run, tests_failed, mon_errs);
        if (tests_failed == 0 && mon_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
hdl/tx_gen_pkg.sv
hdl/gen_ctrl_if.sv
hdl/exec_ctrl_capture.sv
hdl/prbs_lane.sv
hdl/pattern_gen.sv
hdl/prbs_rx_checker.sv
hdl/tx_bist_top.sv
dv/tx_bist_monitor.sv
dv/tb_tx_bist.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_tx_bist
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf $(OBJ_DIR)
